//--- decode_stage.f
+incdir+.
decode_pkg.sv
main_decoder.sv
register_file.sv
special_regs.sv
operand_forward.sv
pipe_reg.sv
decode_stage.sv
decode_checker.sv
decode_tb.sv

//--- decode_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module decode_tb import decode_pkg::*; ();

    localparam int     clk_period   = 20;
    localparam int     reset_cycles = 16;
    localparam int     illegal_runs = 40;
    localparam int     read_runs    = 120;
    localparam int     fwd_runs     = 120;
    localparam int     stall_runs   = 150;
    localparam int     pc_runs      = 60;
    localparam longint count_period = 64'd1 << `DECODE_COUNT_WIDTH;
    // count test runs for at most two count periods.
    localparam longint test_cycles  = reset_cycles + 28 + illegal_runs + read_runs + fwd_runs
                                      + stall_runs + 2 * count_period + pc_runs + 8;
    localparam longint watchdog_ns  = test_cycles * clk_period * 6 / 5;

    logic        pif;
    logic        rst;
    fetch_pkt_t  fetch;
    logic        stall;
    logic        flush;
    writeback_t  wb;
    forward_t    fwd;
    decode_out_t dec_out;
    logic        count_overflow;
    logic [2:0]  test_id;
    logic [2:0]  next_test_id; // takes effect with the next stimulus.
    int          error_count;
    int          check_count;
    int          pulses;
    data_t       pc_next;
    logic [31:0] lfsr = 32'h8e4cf0d2;

    logic [5:0] i_ops [14] = '{op_addiu, op_andi, op_ori, op_xori, op_slti, op_lui, op_lw,
                               op_sw, op_ll, op_sc, op_beq, op_bne, op_j, op_jal};
    logic [5:0] r_fns [14] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sll,
                               fn_srl, fn_jr, fn_mfhi, fn_mflo, fn_mthi, fn_mtlo, fn_mult};

    decode_stage dut0 (
        .pif(pif), .rst(rst), .fetch(fetch), .stall(stall), .flush(flush),
        .wb(wb), .fwd(fwd), .dec_out(dec_out), .count_overflow(count_overflow)
    );

    decode_checker check0 (
        .pif(pif), .rst(rst), .fetch(fetch), .stall(stall), .flush(flush),
        .wb(wb), .fwd(fwd), .dec_out(dec_out), .count_overflow(count_overflow),
        .test_id(test_id), .error_count(error_count), .check_count(check_count)
    );

    // galois lfsr stepped once per bit.
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    // opcode, or function code, outside the subset.
    function automatic logic [5:0] illegal_code(logic is_funct);
        logic [5:0] c;
        logic       hit;
        do begin
            c   = 6'(rand_bits(6));
            hit = !is_funct && c == op_special;
            for (int i = 0; i < 14; i++) begin
                hit = hit || (is_funct ? c == r_fns[i] : c == i_ops[i]);
            end
        end while (hit);
        return c;
    endfunction

    task automatic step();
        @(negedge pif);
        if (count_overflow) pulses++;
        test_id = next_test_id;
        fetch = '0;
        stall = 1'b0;
        flush = 1'b0;
        wb    = '0;
        fwd   = '0;
    endtask

    task automatic send_op(logic [5:0] op, logic [5:0] fn, int reg_bits);
        instr_t w;
        w = rand_bits(32);
        w[31:26] = op;
        if (op == op_special) w[5:0] = fn;
        if (reg_bits < 5) begin
            w[25:21] = reg_addr_t'(rand_bits(reg_bits)); // narrow range gives more hits.
            w[20:16] = reg_addr_t'(rand_bits(reg_bits));
        end
        fetch.valid = 1'b1;
        fetch.instr = w;
        fetch.pc    = pc_next;
        pc_next     = pc_next + 32'd4;
    endtask

    task automatic random_wb(int reg_bits);
        wb.reg_write   = rand_bits(2) != 0;
        wb.dest        = reg_addr_t'(rand_bits(reg_bits));
        wb.data        = rand_bits(32);
        wb.write_hi    = rand_bits(1) != 0;
        wb.hi_data     = rand_bits(32);
        wb.write_lo    = rand_bits(1) != 0;
        wb.lo_data     = rand_bits(32);
        wb.write_llbit = rand_bits(1) != 0;
        wb.llbit       = rand_bits(1) != 0;
    endtask

    initial begin
        pif = 1'b0;
        forever #(clk_period / 2) pif = ~pif;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns with tests still running", watchdog_ns);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int pulse_start;
        rst          = 1'b1;
        fetch        = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        wb           = '0;
        fwd          = '0;
        test_id      = 3'd0;
        next_test_id = 3'd0;
        pulses       = 0;
        pc_next      = 32'h0040_0000;
        repeat (reset_cycles) @(negedge pif);
        rst = 1'b0;

        next_test_id = 3'd1;
        foreach (i_ops[i]) begin
            step();
            send_op(i_ops[i], 6'h00, 5);
        end
        foreach (r_fns[i]) begin
            step();
            send_op(op_special, r_fns[i], 5);
        end
        repeat (illegal_runs) begin
            step();
            if (rand_bits(1) != 0) send_op(illegal_code(1'b0), 6'h00, 5);
            else send_op(op_special, illegal_code(1'b1), 5);
        end

        next_test_id = 3'd2;
        repeat (read_runs) begin
            step();
            random_wb(3);
            send_op(op_special, fn_addu, 3);
        end

        next_test_id = 3'd3;
        repeat (fwd_runs) begin
            step();
            random_wb(2);
            for (int e = 0; e < 2; e++) begin
                fwd[e].valid = rand_bits(1) != 0;
                fwd[e].dest  = reg_addr_t'(rand_bits(2));
                fwd[e].data  = rand_bits(32);
            end
            send_op(op_special, fn_or, 2);
        end

        next_test_id = 3'd4;
        repeat (stall_runs) begin
            step();
            random_wb(5);
            stall = rand_bits(2) == 0;
            flush = rand_bits(3) == 0;
            if (rand_bits(3) != 0) send_op(i_ops[rand_bits(4) % 14], fn_addu, 5);
        end

        next_test_id = 3'd5;
        pulse_start = pulses;
        while (pulses < pulse_start + 2) begin
            step();
            random_wb(5);
            send_op(op_special, r_fns[9 + rand_bits(2)], 5); // hi and lo moves.
        end

        next_test_id = 3'd6;
        repeat (pc_runs) begin
            step();
            pc_next = rand_bits(32);
            send_op(rand_bits(1) != 0 ? op_jal : op_j, 6'h00, 5);
        end

        next_test_id = 3'd0;
        repeat (4) step(); // drain both pipe registers.
        @(posedge pif);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- decode_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module decode_checker import decode_pkg::*; (
    input  wire logic        pif,
    input  wire logic        rst,
    input  wire fetch_pkt_t  fetch,
    input  wire logic        stall,
    input  wire logic        flush,
    input  wire writeback_t  wb,
    input  wire forward_t    fwd,
    input  wire decode_out_t dec_out,
    input  wire logic        count_overflow,
    input  wire logic [2:0]  test_id,
    output int               error_count,
    output int               check_count
);

    localparam longint count_period = 64'd1 << `DECODE_COUNT_WIDTH;

    data_t       regs_m [`DECODE_REG_COUNT];
    data_t       hi_m;
    data_t       lo_m;
    logic        ll_m;
    fetch_pkt_t  held_m;  // input pipe register.
    decode_out_t exp_out; // output pipe register.
    logic [2:0]  held_tid;
    logic [2:0]  exp_tid;
    logic [2:0]  cur_tid;
    longint      edges;   // edges since reset fell.
    logic        active;

    function automatic string test_name(logic [2:0] id);
        case (id)
            3'd1:    return "decode_table";
            3'd2:    return "register_read";
            3'd3:    return "forward_priority";
            3'd4:    return "stall_flush";
            3'd5:    return "special_regs_count";
            3'd6:    return "pc_fields";
            default: return "idle";
        endcase
    endfunction

    function automatic alu_op_t alu_expected(logic [5:0] op, logic [5:0] fn);
        if (op == op_special) begin
            case (fn)
                fn_addu: return alu_add;
                fn_subu: return alu_sub;
                fn_and:  return alu_and;
                fn_or:   return alu_or;
                fn_xor:  return alu_xor;
                fn_slt:  return alu_slt;
                fn_sll:  return alu_sll;
                fn_srl:  return alu_srl;
                default: return alu_pass;
            endcase
        end
        case (op)
            op_addiu, op_lw, op_sw, op_ll, op_sc: return alu_add;
            op_slti:        return alu_slt;
            op_andi:        return alu_and;
            op_ori:         return alu_or;
            op_xori:        return alu_xor;
            op_lui:         return alu_lui;
            op_beq, op_bne: return alu_sub; // compare by subtract.
            default:        return alu_pass;
        endcase
    endfunction

    // entry 1 overrides the file, entry 0 overrides both.
    function automatic data_t operand(reg_addr_t r, forward_t f);
        data_t v;
        v = regs_m[r];
        if (f[1].valid && f[1].dest == r) v = f[1].data;
        if (f[0].valid && f[0].dest == r) v = f[0].data;
        if (r == '0) v = '0;
        return v;
    endfunction

    function automatic decode_out_t ref_decode(fetch_pkt_t p, forward_t f);
        decode_out_t o;
        control_t    c;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] k;
        logic        is_r;
        logic        r_arith;
        logic        i_arith;
        logic        ld;
        logic        st;
        logic        legal;
        op = p.instr[31:26];
        fn = p.instr[5:0];
        k  = p.instr[15:0];
        is_r    = op == op_special;
        r_arith = is_r && fn inside {fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt,
                                     fn_sll, fn_srl};
        i_arith = op inside {op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui};
        ld      = op inside {op_lw, op_ll};
        st      = op inside {op_sw, op_sc};
        legal   = r_arith || i_arith || ld || st || op inside {op_beq, op_bne, op_j, op_jal}
                  || (is_r && fn inside {fn_jr, fn_mfhi, fn_mflo, fn_mthi, fn_mtlo, fn_mult});
        c = '0;
        c.alu_op     = alu_expected(op, fn);
        c.use_imm    = i_arith || ld || st;
        c.reg_write  = r_arith || i_arith || ld || op inside {op_sc, op_jal}
                       || (is_r && fn inside {fn_mfhi, fn_mflo});
        c.mem_read   = ld;
        c.mem_write  = st;
        c.branch_eq  = op == op_beq;
        c.branch_ne  = op == op_bne;
        c.jump       = op inside {op_j, op_jal};
        c.jump_reg   = is_r && fn == fn_jr;
        c.link       = op == op_jal;
        c.read_hi    = is_r && fn == fn_mfhi;
        c.read_lo    = is_r && fn == fn_mflo;
        c.write_hi   = is_r && fn inside {fn_mthi, fn_mult};
        c.write_lo   = is_r && fn inside {fn_mtlo, fn_mult};
        c.load_link  = op == op_ll;
        c.store_cond = op == op_sc;
        c.illegal    = !legal;
        o.valid   = p.valid;
        o.pc      = p.pc;
        o.pcadd4  = p.pc + 32'd4;
        o.pcjump  = {o.pcadd4[31:28], p.instr[25:0], 2'b00};
        o.control = c;
        if (op == op_jal) begin
            o.dest = reg_addr_t'(31);
        end else begin
            o.dest = is_r ? p.instr[15:11] : p.instr[20:16];
        end
        if (op inside {op_andi, op_ori, op_xori}) begin
            o.imm = {16'h0000, k};
        end else if (op == op_lui) begin
            o.imm = {k, 16'h0000};
        end else begin
            o.imm = {{16{k[15]}}, k};
        end
        o.shamt  = p.instr[10:6];
        o.rs_val = operand(p.instr[25:21], f);
        o.rt_val = operand(p.instr[20:16], f);
        o.hi     = hi_m;
        o.lo     = lo_m;
        o.llbit  = ll_m;
        return o;
    endfunction

    task automatic check_value(string tname, string field, logic [127:0] exp,
                               logic [127:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("ERROR %s %s expected %h actual %h", tname, field, exp, act);
        end
    endtask

    // one posedge of the two-register pipe plus the state it reads.
    task automatic update_model();
        decode_out_t nxt;
        cur_tid = test_id;
        if (rst) begin
            foreach (regs_m[i]) regs_m[i] = '0;
            hi_m     = '0;
            lo_m     = '0;
            ll_m     = 1'b0;
            held_m   = '0;
            exp_out  = '0;
            held_tid = '0;
            exp_tid  = '0;
            edges    = 0;
            active   = 1'b0;
        end else begin
            nxt = ref_decode(held_m, fwd); // state before this edge.
            if (!stall) begin
                exp_out  = nxt;
                exp_tid  = held_tid;
                held_m   = fetch;
                held_tid = test_id;
                if (flush) begin
                    exp_out.valid = 1'b0;
                    held_m.valid  = 1'b0;
                end
            end
            if (wb.reg_write && wb.dest != '0) regs_m[wb.dest] = wb.data;
            if (wb.write_hi) hi_m = wb.hi_data;
            if (wb.write_lo) lo_m = wb.lo_data;
            if (wb.write_llbit) ll_m = wb.llbit;
            edges++;
            active = 1'b1;
        end
    endtask

    task automatic compare_outputs();
        string t;
        t = test_name(exp_tid);
        check_value(t, "valid", 128'(exp_out.valid), 128'(dec_out.valid));
        if (exp_out.valid) begin
            check_value(t, "pc/pcadd4/pcjump",
                        128'({exp_out.pc, exp_out.pcadd4, exp_out.pcjump}),
                        128'({dec_out.pc, dec_out.pcadd4, dec_out.pcjump}));
            check_value(t, "control/dest/imm/shamt",
                        128'({exp_out.control, exp_out.dest, exp_out.imm, exp_out.shamt}),
                        128'({dec_out.control, dec_out.dest, dec_out.imm, dec_out.shamt}));
            check_value(t, "rs/rt", 128'({exp_out.rs_val, exp_out.rt_val}),
                        128'({dec_out.rs_val, dec_out.rt_val}));
            check_value(t, "hi/lo/llbit", 128'({exp_out.hi, exp_out.lo, exp_out.llbit}),
                        128'({dec_out.hi, dec_out.lo, dec_out.llbit}));
        end
        check_value(test_name(cur_tid), "count_overflow",
                    128'(edges != 0 && edges % count_period == 0), 128'(count_overflow));
    endtask

    // model steps on the rising edge, outputs are compared mid-cycle.
    initial begin
        error_count = 0;
        check_count = 0;
        active = 1'b0;
        forever begin
            @(posedge pif);
            update_model();
            @(negedge pif);
            if (active) compare_outputs();
        end
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module decode_stage import decode_pkg::*; (
    input  wire logic       pif,
    input  wire logic       rst,
    input  wire fetch_pkt_t fetch,
    input  wire logic       stall,
    input  wire logic       flush,
    input  wire writeback_t wb,
    input  wire forward_t   fwd,
    output decode_out_t     dec_out,
    output logic            count_overflow
);

    fetch_pkt_t  held;
    decode_out_t next_out;
    control_t    ctl;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   dest;
    data_t       imm;
    shamt_t      shamt;
    data_t       rf_a;
    data_t       rf_b;
    data_t       rs_val;
    data_t       rt_val;
    data_t       hi;
    data_t       lo;
    logic        llbit;
    data_t       pcadd4;

    pipe_reg #(.payload_t(fetch_pkt_t)) fetch_reg (
        .pif(pif), .rst(rst), .stall(stall), .flush(flush),
        .d(fetch), .q(held)
    );

    main_decoder decoder (
        .instr(held.instr), .ctl(ctl), .rs(rs), .rt(rt),
        .dest(dest), .imm(imm), .shamt(shamt)
    );

    // writebacks land even while the stage is stalled.
    register_file gpr (
        .pif(pif), .rst(rst),
        .we(wb.reg_write), .waddr(wb.dest), .wdata(wb.data),
        .raddr_a(rs), .raddr_b(rt), .rdata_a(rf_a), .rdata_b(rf_b)
    );

    special_regs sregs (
        .pif(pif), .rst(rst), .wb(wb),
        .hi(hi), .lo(lo), .llbit(llbit), .count_overflow(count_overflow)
    );

    operand_forward forwarder (
        .rs(rs), .rt(rt), .rf_a(rf_a), .rf_b(rf_b), .fwd(fwd),
        .rs_val(rs_val), .rt_val(rt_val)
    );

    assign pcadd4 = held.pc + data_t'(4);

    always_comb begin
        next_out.valid   = held.valid;
        next_out.pc      = held.pc;
        next_out.pcadd4  = pcadd4;
        // jump target keeps the region bits of the delay slot.
        next_out.pcjump  = {pcadd4[`DECODE_DATA_WIDTH-1 -: 4], held.instr[25:0], 2'b00};
        next_out.control = ctl;
        next_out.dest    = dest;
        next_out.imm     = imm;
        next_out.shamt   = shamt;
        next_out.rs_val  = rs_val;
        next_out.rt_val  = rt_val;
        next_out.hi      = hi;
        next_out.lo      = lo;
        next_out.llbit   = llbit;
    end

    pipe_reg #(.payload_t(decode_out_t)) out_reg (
        .pif(pif), .rst(rst), .stall(stall), .flush(flush),
        .d(next_out), .q(dec_out)
    );

endmodule

`default_nettype wire

//--- pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [0:0]
) (
    input  wire logic     pif,
    input  wire logic     rst,
    input  wire logic     stall,
    input  wire logic     flush,
    input  wire payload_t d,
    output payload_t      q
);

    payload_t bubble;

    always_comb begin
        bubble = d;
        bubble[$bits(payload_t)-1] = 1'b0; // valid is the top bit of the payload.
    end

    // stall wins over flush. a flushed slot keeps its payload bits.
    always_ff @(posedge pif) begin
        if (rst) begin
            q <= '0;
        end else if (!stall) begin
            q <= flush ? bubble : d;
        end
    end

endmodule

`default_nettype wire

//--- operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import decode_pkg::*; (
    input  wire reg_addr_t rs,
    input  wire reg_addr_t rt,
    input  wire data_t     rf_a,
    input  wire data_t     rf_b,
    input  wire forward_t  fwd,
    output data_t          rs_val,
    output data_t          rt_val
);

    // execute beats memory, memory beats the register file.
    function automatic data_t pick(reg_addr_t sel, data_t rf_val, forward_t f);
        if (sel == '0) begin
            return '0; // r0 ignores any forward.
        end
        if (f[0].valid && f[0].dest == sel) begin
            return f[0].data;
        end
        if (f[1].valid && f[1].dest == sel) begin
            return f[1].data;
        end
        return rf_val;
    endfunction

    assign rs_val = pick(rs, rf_a, fwd);
    assign rt_val = pick(rt, rf_b, fwd);

endmodule

`default_nettype wire

//--- special_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module special_regs import decode_pkg::*; (
    input  wire logic       pif,
    input  wire logic       rst,
    input  wire writeback_t wb,
    output data_t           hi,
    output data_t           lo,
    output logic            llbit,
    output logic            count_overflow
);

    logic [`DECODE_COUNT_WIDTH-1:0] count;

    always_ff @(posedge pif) begin
        if (rst) begin
            hi    <= '0;
            lo    <= '0;
            llbit <= 1'b0;
        end else begin
            if (wb.write_hi) hi <= wb.hi_data;
            if (wb.write_lo) lo <= wb.lo_data;
            if (wb.write_llbit) llbit <= wb.llbit; // own field, not hi.
        end
    end

    // free-running count. pulse sits in the cycle right after the wrap.
    always_ff @(posedge pif) begin
        if (rst) begin
            count          <= '0;
            count_overflow <= 1'b0;
        end else begin
            count          <= count + 1'b1;
            count_overflow <= &count;
        end
    end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module register_file import decode_pkg::*; (
    input  wire logic      pif,
    input  wire logic      rst,
    input  wire logic      we,
    input  wire reg_addr_t waddr,
    input  wire data_t     wdata,
    input  wire reg_addr_t raddr_a,
    input  wire reg_addr_t raddr_b,
    output data_t          rdata_a,
    output data_t          rdata_b
);

    data_t regs [`DECODE_REG_COUNT];

    // r0 is never written, so it stays at its reset value of zero.
    always_ff @(posedge pif) begin
        if (rst) begin
            for (int i = 0; i < `DECODE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // no write-through. a same-cycle write shows up after the edge.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

//--- main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder import decode_pkg::*; (
    input  wire instr_t instr,
    output control_t    ctl,
    output reg_addr_t   rs,
    output reg_addr_t   rt,
    output reg_addr_t   dest,
    output data_t       imm,
    output shamt_t      shamt
);

    localparam int data_w = $bits(data_t);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rd;

    function automatic alu_op_t r_alu(funct_t f);
        case (f)
            fn_addu: return alu_add;
            fn_subu: return alu_sub;
            fn_and:  return alu_and;
            fn_or:   return alu_or;
            fn_xor:  return alu_xor;
            fn_slt:  return alu_slt;
            fn_sll:  return alu_sll;
            fn_srl:  return alu_srl;
            default: return alu_pass; // moves, jr and mult.
        endcase
    endfunction

    function automatic alu_op_t i_alu(opcode_t op);
        case (op)
            op_addiu, op_lw, op_sw, op_ll, op_sc: return alu_add; // address adds too.
            op_slti:         return alu_slt;
            op_andi:         return alu_and;
            op_ori:          return alu_or;
            op_xori:         return alu_xor;
            op_lui:          return alu_lui;
            op_beq, op_bne:  return alu_sub;
            default:         return alu_pass;
        endcase
    endfunction

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];

    always_comb begin
        ctl = '0;
        ctl.alu_op = (opcode == op_special) ? r_alu(funct) : i_alu(opcode);
        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sll, fn_srl:
                        ctl.reg_write = 1'b1;
                    fn_jr: ctl.jump_reg = 1'b1;
                    fn_mfhi: begin
                        ctl.read_hi   = 1'b1;
                        ctl.reg_write = 1'b1;
                    end
                    fn_mflo: begin
                        ctl.read_lo   = 1'b1;
                        ctl.reg_write = 1'b1;
                    end
                    fn_mthi: ctl.write_hi = 1'b1;
                    fn_mtlo: ctl.write_lo = 1'b1;
                    fn_mult: begin
                        // product lands in hi and lo.
                        ctl.write_hi = 1'b1;
                        ctl.write_lo = 1'b1;
                    end
                    default: ctl.illegal = 1'b1;
                endcase
            end
            op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: begin
                ctl.use_imm   = 1'b1;
                ctl.reg_write = 1'b1;
            end
            op_lw, op_ll: begin
                ctl.use_imm   = 1'b1;
                ctl.reg_write = 1'b1;
                ctl.mem_read  = 1'b1;
                ctl.load_link = (opcode == op_ll);
            end
            op_sw: begin
                ctl.use_imm   = 1'b1;
                ctl.mem_write = 1'b1;
            end
            op_sc: begin
                ctl.use_imm    = 1'b1;
                ctl.mem_write  = 1'b1;
                ctl.store_cond = 1'b1;
                ctl.reg_write  = 1'b1; // success flag goes back to rt.
            end
            op_beq: ctl.branch_eq = 1'b1;
            op_bne: ctl.branch_ne = 1'b1;
            op_j:   ctl.jump = 1'b1;
            op_jal: begin
                ctl.jump      = 1'b1;
                ctl.link      = 1'b1;
                ctl.reg_write = 1'b1;
            end
            default: ctl.illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (opcode)
            op_andi, op_ori, op_xori: imm = {{(data_w-16){1'b0}}, instr[15:0]};
            op_lui:                   imm = {instr[15:0], {(data_w-16){1'b0}}};
            default:                  imm = {{(data_w-16){instr[15]}}, instr[15:0]};
        endcase
    end

    always_comb begin
        if (opcode == op_jal) begin
            dest = '1; // r31, the link register.
        end else if (opcode == op_special) begin
            dest = rd;
        end else begin
            dest = rt;
        end
    end

endmodule

`default_nettype wire

//--- decode_pkg.sv
`default_nettype none
`include "decode_settings.svh"

package decode_pkg;

    typedef logic [`DECODE_DATA_WIDTH-1:0] data_t;
    typedef logic [$clog2(`DECODE_REG_COUNT)-1:0] reg_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] shamt_t;

    // primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b,
        op_ll      = 6'h30,
        op_sc      = 6'h38
    } opcode_t;

    // function codes under op_special.
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_jr   = 6'h08,
        fn_mfhi = 6'h10,
        fn_mthi = 6'h11,
        fn_mflo = 6'h12,
        fn_mtlo = 6'h13,
        fn_mult = 6'h18,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_lui, alu_pass
    } alu_op_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
        data_t  pc;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    jump_reg;
        logic    link;
        logic    read_hi;
        logic    read_lo;
        logic    write_hi;
        logic    write_lo;
        logic    load_link;
        logic    store_cond;
        logic    illegal;
    } control_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        data_t     data;
        logic      write_hi;
        data_t     hi_data;
        logic      write_lo;
        data_t     lo_data;
        logic      write_llbit;
        logic      llbit;
    } writeback_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest; // register the later stage is producing.
        data_t     data;
    } forward_entry_t;

    // entry 0 is execute, entry 1 is memory.
    typedef forward_entry_t [1:0] forward_t;

    typedef struct packed {
        logic      valid;
        data_t     pc;
        data_t     pcadd4;
        data_t     pcjump;
        control_t  control;
        reg_addr_t dest;
        data_t     imm;
        shamt_t    shamt;
        data_t     rs_val;
        data_t     rt_val;
        data_t     hi;
        data_t     lo;
        logic      llbit;
    } decode_out_t;

endpackage

`default_nettype wire

//--- decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// general register file depth.
`define DECODE_REG_COUNT 32

// word width of data, pc and immediates.
`define DECODE_DATA_WIDTH 32

// kept small so the wrap shows up early in simulation.
// anything from 4 to 32 works.
`define DECODE_COUNT_WIDTH 8

`endif
